//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_pipeline
FILELIST  = project.f
OBJ_DIR   = obj_dir
PASS_MSG  = Testbench passed

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the simulator output
run: compile
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- common/pipe_params.svh
`ifndef PIPE_PARAMS_SVH
`define PIPE_PARAMS_SVH

// datapath widths
`define PC_W          8
`define REG_W         3

// a retiring trap restarts fetch here
`define TRAP_VECTOR   8'hF0

// total cycles a multiply/divide spends in EX
`define MULDIV_CYCLES 4

// stage vector layout, oldest stage in the top bit
`define STAGES        5
`define STG_PC        0
`define STG_IF_ID     1
`define STG_ID_EX     2
`define STG_EX_MEM    3
`define STG_MEM_WB    4

`endif

//--- common/pipe_pkg.sv
`include "pipe_params.svh"

package pipe_pkg;

  // instruction classes seen by the sequencing logic
  typedef enum logic [2:0] {
    OP_ALU,
    OP_LOAD,
    OP_MULDIV,
    OP_JUMP,
    OP_TRAP
  } op_e;

  // 20 bit instruction word
  typedef struct packed {
    op_e               op;
    logic [`REG_W-1:0] rd;
    logic [`REG_W-1:0] rs1;
    logic [`REG_W-1:0] rs2;
    logic [`PC_W-1:0]  target;  // jump destination
  } instr_t;

  // one bit per stage, see STG_* indices
  typedef logic [`STAGES-1:0] stage_vec_t;

  // payload carried by every stage register
  typedef struct packed {
    logic [`PC_W-1:0] pc;
    instr_t           instr;
  } stage_entry_t;

endpackage

//--- project.f
+incdir+common
common/pipe_pkg.sv
verilog/pipe_pc.sv
verilog/stage_reg.sv
verilog/decode_unit.sv
verilog/execute_unit.sv
verilog/pipeline_control.sv
verilog/pipeline_top.sv
tb/tb_pipeline.sv

//--- tb/tb_pipeline.sv
`timescale 1ns/100ps
`include "pipe_params.svh"

module tb_pipeline
  import pipe_pkg::*;
();

  logic             clk;
  logic             rst;
  logic             if_rdata_valid;
  instr_t           if_instr;
  logic             mem_stall;
  logic [`PC_W-1:0] fetch_pc;
  logic             retire_valid;
  logic [`PC_W-1:0] retire_pc;
  op_e              retire_op;

  instr_t           imem [0:255];  // program seen by fetch and by the model
  integer           seed;
  int               stall_burst;   // cycles left of a forced long stall
  int               stall_run;     // stalled edges in a row
  int               long_stalls;
  logic             prev_valid;
  logic [`PC_W-1:0] prev_pc;
  logic [`PC_W-1:0] model_pc;      // next PC the model expects to retire
  op_e              last_op;
  logic [`PC_W-1:0] last_target;

  pipeline_top u_pipeline_top (
    .clk              (clk),
    .rst              (rst),
    .if_rdata_valid_i (if_rdata_valid),
    .if_instr_i       (if_instr),
    .mem_stall_i      (mem_stall),
    .fetch_pc_o       (fetch_pc),
    .retire_valid_o   (retire_valid),
    .retire_pc_o      (retire_pc),
    .retire_op_o      (retire_op)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic stop_on_error(input string what);
    $display("%s (time %0t)", what, $time);
    $display("Testbench failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("CHECK FAILED %s expected 0x%0h actual 0x%0h",
                              name, expected, actual));
    end
  endtask

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
  endfunction

  // rough instruction mix, traps kept rare
  function automatic op_e pick_op(input int r);
    if (r < 40) return OP_ALU;
    if (r < 65) return OP_LOAD;
    if (r < 80) return OP_MULDIV;
    if (r < 94) return OP_JUMP;
    return OP_TRAP;
  endfunction

  task automatic fill_imem();
    instr_t ins;
    for (int a = 0; a < 256; a++) begin
      ins.op     = pick_op(rand_below(100));
      ins.rd     = 3'(rand_below(8));  // only 8 registers, so hazards are common
      ins.rs1    = 3'(rand_below(8));
      ins.rs2    = 3'(rand_below(8));
      ins.target = 8'(rand_below(256));
      imem[a]    = ins;
    end
  endtask

  // architectural successor of one instruction
  function automatic logic [`PC_W-1:0] model_next_pc(input logic [`PC_W-1:0] pc);
    case (imem[pc].op)
      OP_JUMP: return imem[pc].target;
      OP_TRAP: return `TRAP_VECTOR;
      default: return pc + 1'b1;
    endcase
  endfunction

  task automatic drive_inputs();
    if (stall_burst > 0) begin
      mem_stall   = 1'b1;
      stall_burst = stall_burst - 1;
    end else if (rand_below(64) == 0) begin
      mem_stall   = 1'b1;
      stall_burst = 5;  // six stalled cycles in all
    end else begin
      mem_stall = (rand_below(100) < 15);
    end
    if_rdata_valid = (rand_below(100) < 75);
    if_instr       = imem[fetch_pc];  // answer the PC currently on the bus
  endtask

  // one falling edge: sample outputs, then drive the next inputs
  task automatic next_cycle();
    @(negedge clk);
    if (mem_stall) begin
      stall_run = stall_run + 1;
      // WB must hold a bubble after any stalled edge
      check_value("memory stall", 0, 32'(retire_valid));
      if (stall_run == 5) long_stalls = long_stalls + 1;
    end else begin
      stall_run = 0;
    end
    if (retire_valid && prev_valid) begin
      check_value("single retire pulse", 1, 32'(retire_pc != prev_pc));
    end
    prev_valid = retire_valid;
    prev_pc    = retire_pc;
    drive_inputs();
  endtask

  task automatic wait_retire();
    int waited;
    waited = 0;
    do begin
      next_cycle();
      waited = waited + 1;
    end while (!retire_valid && waited < 200);
    if (!retire_valid) begin
      stop_on_error("no instruction retired within 200 cycles");
    end
  endtask

  initial begin
    seed           = 3;
    rst            = 1'b1;
    if_rdata_valid = 1'b0;
    if_instr       = '0;
    mem_stall      = 1'b0;
    stall_burst    = 0;
    stall_run      = 0;
    long_stalls    = 0;
    prev_valid     = 1'b0;
    prev_pc        = '0;
    model_pc       = '0;
    last_op        = OP_ALU;
    last_target    = '0;
    fill_imem();

    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
      check_value("reset retire valid", 0, 32'(retire_valid));
      check_value("reset fetch pc", 0, 32'(fetch_pc));
    end
    rst = 1'b0;
    // no fetch offered yet, so the first edge out of reset keeps the PC at 0
    @(negedge clk);
    check_value("first cycle retire valid", 0, 32'(retire_valid));
    check_value("first cycle fetch pc", 0, 32'(fetch_pc));
    drive_inputs();

    for (int n = 0; n < 400; n++) begin
      wait_retire();
      check_value("program order pc", 32'(model_pc), 32'(retire_pc));
      check_value("program order op", 32'(imem[model_pc].op), 32'(retire_op));
      if (last_op == OP_JUMP) begin
        check_value("jump redirect", 32'(last_target), 32'(retire_pc));
      end
      if (last_op == OP_TRAP) begin
        check_value("trap redirect", 32'(`TRAP_VECTOR), 32'(retire_pc));
      end
      last_op     = imem[model_pc].op;
      last_target = imem[model_pc].target;
      model_pc    = model_next_pc(model_pc);
    end

    if (long_stalls == 0) begin
      stop_on_error("no memory stall longer than four cycles was applied");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

//--- verilog/decode_unit.sv
`timescale 1ns/100ps
`include "pipe_params.svh"

module decode_unit
  import pipe_pkg::*;
(
  input  logic   id_valid_i,
  input  instr_t id_instr_i,
  input  logic   ex_valid_i,
  input  instr_t ex_instr_i,
  output logic   load_use_o
);

  logic [`REG_W-1:0] id_rs1;
  logic [`REG_W-1:0] id_rs2;
  logic [`REG_W-1:0] ex_rd;
  logic              id_reads;
  logic              ex_is_load;
  logic              src_match;

  // field extraction
  assign id_rs1 = id_instr_i.rs1;
  assign id_rs2 = id_instr_i.rs2;
  assign ex_rd  = ex_instr_i.rd;

  // jumps and traps carry no source operands
  always_comb begin
    case (id_instr_i.op)
      OP_ALU, OP_LOAD, OP_MULDIV: id_reads = 1'b1;
      default:                    id_reads = 1'b0;
    endcase
  end

  assign ex_is_load = ex_valid_i && (ex_instr_i.op == OP_LOAD);
  assign src_match  = (ex_rd == id_rs1) || (ex_rd == id_rs2);

  // load data is not ready until MEM, so the reader waits one cycle
  assign load_use_o = ex_is_load && id_valid_i && id_reads && src_match;

endmodule

//--- verilog/execute_unit.sv
`timescale 1ns/100ps
`include "pipe_params.svh"

module execute_unit
  import pipe_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             ex_valid_i,
  input  instr_t           ex_instr_i,
  output logic             muldiv_busy_o,
  output logic             jump_o,
  output logic [`PC_W-1:0] jump_target_o
);

  localparam int CNT_W = $clog2(`MULDIV_CYCLES + 1);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`MULDIV_CYCLES - 1);

  logic             ex_muldiv;
  logic [CNT_W-1:0] muldiv_cnt;

  assign ex_muldiv = ex_valid_i && (ex_instr_i.op == OP_MULDIV);

  // busy from entry until the count reaches the last cycle
  assign muldiv_busy_o = ex_muldiv && (muldiv_cnt != LAST_CNT);

  // counter restarts on the release cycle so back to back ops each get full length;
  // an op held by a memory stall on that cycle simply runs again
  always_ff @(posedge clk) begin
    if (rst) begin
      muldiv_cnt <= '0;
    end else if (muldiv_busy_o) begin
      muldiv_cnt <= muldiv_cnt + 1'b1;
    end else begin
      muldiv_cnt <= '0;
    end
  end

  // jumps resolve in EX
  assign jump_o        = ex_valid_i && (ex_instr_i.op == OP_JUMP);
  assign jump_target_o = ex_instr_i.target;

  a_cnt_range: assert property (
    @(posedge clk) disable iff (rst)
    muldiv_cnt <= CNT_W'(`MULDIV_CYCLES)
  ) else $error("muldiv counter overran");

endmodule

//--- verilog/pipe_pc.sv
`timescale 1ns/100ps
`include "pipe_params.svh"

module pipe_pc (
  input  logic             clk,
  input  logic             rst,
  input  logic             stall_i,
  input  logic             redirect_i,
  input  logic [`PC_W-1:0] redirect_pc_i,
  output logic [`PC_W-1:0] pc_o
);

  logic [`PC_W-1:0] pc_next;

  // redirect beats stall, a jump or trap must never be lost
  always_comb begin
    if (redirect_i) begin
      pc_next = redirect_pc_i;
    end else if (stall_i) begin
      pc_next = pc_o;
    end else begin
      pc_next = pc_o + 1'b1;  // one instruction per address
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_o <= '0;
    end else begin
      pc_o <= pc_next;
    end
  end

  // a held PC refetches the same address next cycle
  a_pc_hold: assert property (
    @(posedge clk) disable iff (rst)
    (stall_i && !redirect_i) |=> (pc_o == $past(pc_o))
  ) else $error("pc moved while stalled");

endmodule

//--- verilog/pipeline_control.sv
`timescale 1ns/100ps

module pipeline_control
  import pipe_pkg::*;
(
  input  logic       rst,
  input  logic       if_rdata_valid_i,
  input  logic       mem_stall_i,
  input  logic       trap_wb_i,
  input  logic       muldiv_busy_i,
  input  logic       jump_i,
  input  logic       load_use_i,
  output stage_vec_t stall_o,
  output stage_vec_t flush_o,
  output logic       redirect_o,
  output logic       redirect_pc_sel_o  // 1 picks the trap vector
);

  // bit order MEM_WB, EX_MEM, ID_EX, IF_ID, PC
  localparam stage_vec_t none_vec        = 5'b00000;
  localparam stage_vec_t rst_flush       = 5'b11111;

  localparam stage_vec_t trap_flush      = 5'b11110;  // everything younger than WB

  localparam stage_vec_t mem_stall_stall = 5'b01111;
  localparam stage_vec_t mem_stall_flush = 5'b10000;

  localparam stage_vec_t muldiv_stall    = 5'b00111;
  localparam stage_vec_t muldiv_flush    = 5'b01000;

  localparam stage_vec_t jump_flush      = 5'b00110;  // wrong path in IF and ID

  localparam stage_vec_t load_use_stall  = 5'b00011;
  localparam stage_vec_t load_use_flush  = 5'b00100;

  localparam stage_vec_t fetch_stall     = 5'b00001;
  localparam stage_vec_t fetch_flush     = 5'b00010;

  stage_vec_t stall_c;
  stage_vec_t flush_c;
  logic       redirect_c;
  logic       trap_sel_c;

  // older stage wins
  always_comb begin
    stall_c    = none_vec;
    flush_c    = none_vec;
    redirect_c = 1'b0;
    trap_sel_c = 1'b0;
    if (rst) begin
      flush_c = rst_flush;
    end else if (trap_wb_i) begin
      flush_c    = trap_flush;
      redirect_c = 1'b1;
      trap_sel_c = 1'b1;
    end else if (mem_stall_i) begin
      stall_c = mem_stall_stall;  // hold MEM and everything behind it
      flush_c = mem_stall_flush;
    end else if (muldiv_busy_i) begin
      stall_c = muldiv_stall;
      flush_c = muldiv_flush;
    end else if (jump_i) begin
      flush_c    = jump_flush;
      redirect_c = 1'b1;
    end else if (load_use_i) begin
      stall_c = load_use_stall;  // bubble goes into EX
      flush_c = load_use_flush;
    end else if (!if_rdata_valid_i) begin
      stall_c = fetch_stall;
      flush_c = fetch_flush;
    end

    // every row above keeps the two vectors apart
    a_disjoint: assert ((stall_c & flush_c) == none_vec)
      else $error("stall and flush overlap");
  end

  assign stall_o           = stall_c;
  assign flush_o           = flush_c;
  assign redirect_o        = redirect_c;
  assign redirect_pc_sel_o = trap_sel_c;

endmodule

//--- verilog/pipeline_top.sv
`timescale 1ns/100ps
`include "pipe_params.svh"

module pipeline_top
  import pipe_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             if_rdata_valid_i,
  input  instr_t           if_instr_i,
  input  logic             mem_stall_i,
  output logic [`PC_W-1:0] fetch_pc_o,
  output logic             retire_valid_o,
  output logic [`PC_W-1:0] retire_pc_o,
  output op_e              retire_op_o
);

  stage_vec_t       stall_v;
  stage_vec_t       flush_v;
  logic             redirect;
  logic             redirect_sel;
  logic [`PC_W-1:0] redirect_pc;
  logic [`PC_W-1:0] jump_target;
  logic             load_use;
  logic             muldiv_busy;
  logic             jump;
  logic             trap_wb;

  stage_entry_t     if_entry;
  logic             if_id_valid;
  stage_entry_t     if_id_data;
  logic             id_ex_valid;
  stage_entry_t     id_ex_data;
  logic             ex_mem_valid;
  stage_entry_t     ex_mem_data;
  logic             mem_wb_valid;
  stage_entry_t     mem_wb_data;

  // trap wins the PC mux over a jump
  assign redirect_pc = redirect_sel ? `TRAP_VECTOR : jump_target;

  pipe_pc u_pipe_pc (
    .clk           (clk),
    .rst           (rst),
    .stall_i       (stall_v[`STG_PC]),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .pc_o          (fetch_pc_o)
  );

  assign if_entry = '{pc: fetch_pc_o, instr: if_instr_i};  // fetch answers the current PC

  stage_reg #(.payload_t(stage_entry_t)) u_if_id (
    .clk (clk), .rst (rst),
    .stall_i (stall_v[`STG_IF_ID]), .flush_i (flush_v[`STG_IF_ID]),
    .valid_i (if_rdata_valid_i),    .data_i  (if_entry),
    .valid_o (if_id_valid),         .data_o  (if_id_data)
  );

  stage_reg #(.payload_t(stage_entry_t)) u_id_ex (
    .clk (clk), .rst (rst),
    .stall_i (stall_v[`STG_ID_EX]), .flush_i (flush_v[`STG_ID_EX]),
    .valid_i (if_id_valid),         .data_i  (if_id_data),
    .valid_o (id_ex_valid),         .data_o  (id_ex_data)
  );

  stage_reg #(.payload_t(stage_entry_t)) u_ex_mem (
    .clk (clk), .rst (rst),
    .stall_i (stall_v[`STG_EX_MEM]), .flush_i (flush_v[`STG_EX_MEM]),
    .valid_i (id_ex_valid),          .data_i  (id_ex_data),
    .valid_o (ex_mem_valid),         .data_o  (ex_mem_data)
  );

  stage_reg #(.payload_t(stage_entry_t)) u_mem_wb (
    .clk (clk), .rst (rst),
    .stall_i (stall_v[`STG_MEM_WB]), .flush_i (flush_v[`STG_MEM_WB]),
    .valid_i (ex_mem_valid),         .data_i  (ex_mem_data),
    .valid_o (mem_wb_valid),         .data_o  (mem_wb_data)
  );

  decode_unit u_decode_unit (
    .id_valid_i (if_id_valid),
    .id_instr_i (if_id_data.instr),
    .ex_valid_i (id_ex_valid),
    .ex_instr_i (id_ex_data.instr),
    .load_use_o (load_use)
  );

  execute_unit u_execute_unit (
    .clk           (clk),
    .rst           (rst),
    .ex_valid_i    (id_ex_valid),
    .ex_instr_i    (id_ex_data.instr),
    .muldiv_busy_o (muldiv_busy),
    .jump_o        (jump),
    .jump_target_o (jump_target)
  );

  // trap takes effect as it retires
  assign trap_wb = mem_wb_valid && (mem_wb_data.instr.op == OP_TRAP);

  pipeline_control u_pipeline_control (
    .rst               (rst),
    .if_rdata_valid_i  (if_rdata_valid_i),
    .mem_stall_i       (mem_stall_i),
    .trap_wb_i         (trap_wb),
    .muldiv_busy_i     (muldiv_busy),
    .jump_i            (jump),
    .load_use_i        (load_use),
    .stall_o           (stall_v),
    .flush_o           (flush_v),
    .redirect_o        (redirect),
    .redirect_pc_sel_o (redirect_sel)
  );

  assign retire_valid_o = mem_wb_valid;
  assign retire_pc_o    = mem_wb_data.pc;
  assign retire_op_o    = mem_wb_data.instr.op;

endmodule

//--- verilog/stage_reg.sv
`timescale 1ns/100ps

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     stall_i,
  input  logic     flush_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  // valid bit is the only control state here
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      valid_o <= 1'b0;  // bubble
    end else if (!stall_i) begin
      valid_o <= valid_i;
    end
  end

  // payload follows the valid bit, contents of a bubble don't matter
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      data_o <= data_i;
    end
  end

  // control never asks one stage to hold and empty at once
  a_no_stall_flush: assert property (
    @(posedge clk) !(stall_i && flush_i)
  ) else $error("stage got stall and flush together");

endmodule
